// ==== muldiv_pkg.sv ====
/*
 * Shared types and sizes for the RV32M multiply/divide unit.
 * Any operation code outside the M group is treated as a non-M operation.
 */
package muldiv_pkg;

    localparam int XLEN      = 32;
    localparam int DIV_STEPS = 32;                  // One quotient bit per cycle.
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // Execute-stage operation code.
    // NOP and ADD represent every operation outside the M extension.
    typedef enum logic [3:0] {
        NOP    = 4'h0,
        ADD    = 4'h1,
        MUL    = 4'h2,
        MULH   = 4'h3,
        MULHSU = 4'h4,
        MULHU  = 4'h5,
        DIV    = 4'h6,
        DIVU   = 4'h7,
        REM    = 4'h8,
        REMU   = 4'h9
    } iType_e;

    // Request as sampled from the core, 68 bits.
    typedef struct packed {
        logic [XLEN-1:0] first_operand;
        logic [XLEN-1:0] second_operand;
        iType_e          operation;
    } muldiv_req_t;

    // Multiplier group.
    function automatic logic is_mul_op(input iType_e op);
        return op inside {MUL, MULH, MULHSU, MULHU};
    endfunction

    // Divider group.
    function automatic logic is_div_op(input iType_e op);
        return op inside {DIV, DIVU, REM, REMU};
    endfunction

    function automatic logic is_signed_div(input iType_e op);
        return op inside {DIV, REM};
    endfunction

    // Remainder instead of quotient.
    function automatic logic is_rem_op(input iType_e op);
        return op inside {REM, REMU};
    endfunction

    // Two's complement negate when requested.
    function automatic logic [XLEN-1:0] neg_if(input logic [XLEN-1:0] value,
                                               input logic            negate);
        return negate ? (~value + 1'b1) : value;
    endfunction

endpackage

// ==== mul.sv ====
/*
 * Multi-cycle multiplier on a single 17x17 signed MAC.
 * MUL finishes in cycle 3, MULH/MULHSU/MULHU in cycle 4.
 * Operands and operation must stay stable while hold_o is high.
 */
module mul
    import muldiv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] first_operand_i,
    input  logic [XLEN-1:0] second_operand_i,
    input  iType_e          instruction_operation_i,

    output logic            hold_o,
    output logic [XLEN-1:0] mul_result_o
);

    // Which pair of operand halves goes through the MAC.
    typedef enum logic [1:0] {
        ALBL,
        ALBH,
        AHBL,
        AHBH
    } mul_state_e;

    mul_state_e  state;
    mul_state_e  next_state;

    logic [34:0] mac_result;
    logic [34:0] mac_partial;
    logic [34:0] mac_reg;
    logic [34:0] accum;
    logic [15:0] op_a;
    logic [15:0] op_b;
    logic        sign_a;
    logic        sign_b;
    logic        a_signed;                          // High half of A is signed.
    logic        b_signed;                          // High half of B is signed.
    logic        start;
    logic        low_word;

    assign a_signed = instruction_operation_i inside {MULH, MULHSU};
    assign b_signed = (instruction_operation_i == MULH);
    assign low_word = (instruction_operation_i == MUL);
    assign start    = (state == ALBL) && is_mul_op(instruction_operation_i);

    assign mac_result = $signed({sign_a, op_a}) * $signed({sign_b, op_b}) + $signed(accum);

    assign mul_result_o = mac_partial[31:0];

    always_comb begin
        op_a        = first_operand_i[15:0];
        op_b        = second_operand_i[15:0];
        sign_a      = 1'b0;
        sign_b      = 1'b0;
        accum       = '0;
        mac_partial = mac_result;
        next_state  = state;
        hold_o      = 1'b0;

        unique case (state)
            ALBL: begin
                // Low halves, both unsigned.
                if (start) begin
                    next_state = ALBH;
                    hold_o     = 1'b1;
                end else begin
                    next_state = ALBL;
                    hold_o     = 1'b0;
                end
            end
            ALBH: begin
                op_b   = second_operand_i[31:16];
                sign_b = b_signed & second_operand_i[31];
                accum  = {19'b0, mac_reg[31:16]};   // Carry in from AL*BL.
                if (low_word) begin
                    mac_partial = {3'b0, mac_result[15:0], mac_reg[15:0]};
                end
                next_state = AHBL;
                hold_o     = 1'b1;
            end
            AHBL: begin
                op_a   = first_operand_i[31:16];
                sign_a = a_signed & first_operand_i[31];
                if (low_word) begin
                    // Only the low 16 bits of the middle sum matter here.
                    accum       = {19'b0, mac_reg[31:16]};
                    mac_partial = {3'b0, mac_result[15:0], mac_reg[15:0]};
                    next_state  = ALBL;
                    hold_o      = 1'b0;
                end else begin
                    accum      = mac_reg;
                    next_state = AHBH;
                    hold_o     = 1'b1;
                end
            end
            AHBH: begin
                op_a   = first_operand_i[31:16];
                op_b   = second_operand_i[31:16];
                sign_a = a_signed & first_operand_i[31];
                sign_b = b_signed & second_operand_i[31];
                // Middle sum shifted down by 16.
                accum  = {{16{a_signed & mac_reg[34]}}, mac_reg[34:16]};
                next_state = ALBL;
                hold_o     = 1'b0;
            end
            default: begin
                next_state = ALBL;
                hold_o     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        mac_reg <= mac_partial;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ALBL;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== div.sv ====
/*
 * Radix-2 restoring divider, fixed latency of DIV_STEPS+2 cycles.
 * Division by zero and signed overflow return the RISC-V defined values.
 * Operands and operation must stay stable until the final cycle.
 */
module div
    import muldiv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] first_operand_i,
    input  logic [XLEN-1:0] second_operand_i,
    input  iType_e          instruction_operation_i,

    output logic            hold_o,
    output logic [XLEN-1:0] div_result_o
);

    // Operands are loaded on the edge that leaves DIV_IDLE.
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ITER,
        DIV_DONE
    } div_state_e;

    div_state_e           state;
    div_state_e           next_state;
    logic [DIV_CNT_W-1:0] step_cnt;

    logic [XLEN-1:0]      rem_q;                    // Partial remainder.
    logic [XLEN-1:0]      quot_q;                   // Dividend shifts out, quotient in.
    logic [XLEN-1:0]      divisor_q;

    logic                 signed_op;
    logic                 dividend_neg;
    logic                 divisor_neg;
    logic [XLEN-1:0]      dividend_abs;
    logic [XLEN-1:0]      divisor_abs;
    logic [XLEN:0]        rem_shift;
    logic [XLEN+1:0]      trial;
    logic                 fits;
    logic                 div_by_zero;
    logic                 overflow;
    logic [XLEN-1:0]      quot_res;
    logic [XLEN-1:0]      rem_res;

    assign signed_op    = is_signed_div(instruction_operation_i);
    assign dividend_neg = signed_op & first_operand_i[XLEN-1];
    assign divisor_neg  = signed_op & second_operand_i[XLEN-1];
    assign dividend_abs = neg_if(first_operand_i, dividend_neg);
    assign divisor_abs  = neg_if(second_operand_i, divisor_neg);

    // One shift-subtract step.
    assign rem_shift = {rem_q, quot_q[XLEN-1]};
    assign trial     = {1'b0, rem_shift} - {2'b0, divisor_q};
    assign fits      = ~trial[XLEN+1];

    always_comb begin
        next_state = state;
        hold_o     = 1'b0;
        unique case (state)
            DIV_IDLE: begin
                if (is_div_op(instruction_operation_i)) begin
                    next_state = DIV_ITER;
                    hold_o     = 1'b1;
                end
            end
            DIV_ITER: begin
                hold_o = 1'b1;
                if (step_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
                    next_state = DIV_DONE;
                end
            end
            DIV_DONE: begin
                next_state = DIV_IDLE;          // Result valid this cycle.
            end
            default: begin
                next_state = DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == DIV_ITER) begin
                step_cnt <= step_cnt + 1'b1;
            end else begin
                step_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE) begin
            rem_q     <= '0;
            quot_q    <= dividend_abs;
            divisor_q <= divisor_abs;
        end else if (state == DIV_ITER) begin
            rem_q  <= fits ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];
            quot_q <= {quot_q[XLEN-2:0], fits};
        end
    end

    // Sign correction and corner cases.
    assign div_by_zero = (second_operand_i == '0);
    assign overflow    = signed_op && (first_operand_i == {1'b1, {(XLEN-1){1'b0}}})
                         && (second_operand_i == '1);

    always_comb begin
        if (div_by_zero) begin
            quot_res = '1;
            rem_res  = first_operand_i;
        end else if (overflow) begin
            quot_res = {1'b1, {(XLEN-1){1'b0}}};
            rem_res  = '0;
        end else begin
            quot_res = neg_if(quot_q, dividend_neg ^ divisor_neg);
            rem_res  = neg_if(rem_q, dividend_neg);   // Remainder takes dividend's sign.
        end
    end

    assign div_result_o = is_rem_op(instruction_operation_i) ? rem_res : quot_res;

endmodule

// ==== muldiv_unit.sv ====
/*
 * RV32M execute-stage block combining multiplier and divider.
 * No handshake: the request is a level held stable while hold_o is high.
 * Non-M operations give hold_o low and a zero result.
 */
module muldiv_unit
    import muldiv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  muldiv_req_t     req_i,

    output logic            hold_o,
    output logic [XLEN-1:0] result_o
);

    logic            mul_hold;
    logic            div_hold;
    logic [XLEN-1:0] mul_result;
    logic [XLEN-1:0] div_result;

    // Each unit decodes the operation itself.
    mul i_mul (
        .clk                     (clk),
        .reset                   (reset),
        .first_operand_i         (req_i.first_operand),
        .second_operand_i        (req_i.second_operand),
        .instruction_operation_i (req_i.operation),
        .hold_o                  (mul_hold),
        .mul_result_o            (mul_result)
    );

    div i_div (
        .clk                     (clk),
        .reset                   (reset),
        .first_operand_i         (req_i.first_operand),
        .second_operand_i        (req_i.second_operand),
        .instruction_operation_i (req_i.operation),
        .hold_o                  (div_hold),
        .div_result_o            (div_result)
    );

    assign hold_o = mul_hold | div_hold;

    always_comb begin
        if (is_mul_op(req_i.operation)) begin
            result_o = mul_result;
        end else if (is_div_op(req_i.operation)) begin
            result_o = div_result;
        end else begin
            result_o = '0;                      // Not an M operation.
        end
    end

endmodule

// ==== muldiv_properties.sv ====
/*
 * Concurrent checks on hold_o, bound into muldiv_unit.
 * Assumes the request stays stable while hold_o is high.
 */
module muldiv_properties
    import muldiv_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input muldiv_req_t req_i,
    input logic        hold_i
);

    logic non_m;

    assign non_m = !(is_mul_op(req_i.operation) || is_div_op(req_i.operation));

    // First cycle out of reset, both units idle.
    hold_low_after_reset: assert property (@(posedge clk)
        (!reset && $past(reset)) |-> (hold_i == !non_m))
        else $error("hold_o wrong in the first cycle after reset");

    hold_bounded: assert property (@(posedge clk) disable iff (reset)
        hold_i [*(DIV_STEPS + 1)] |=> !hold_i)
        else $error("hold_o high for more than DIV_STEPS+1 cycles");

    hold_low_non_m: assert property (@(posedge clk) disable iff (reset)
        non_m |-> !hold_i)                          // No stall outside the M group.
        else $error("hold_o high for a non-M request");

endmodule

// ==== tb_muldiv.sv ====
/*
 * Self-checking testbench for muldiv_unit with seeded random stimulus.
 * Requests are driven on the falling edge and held until hold_o drops.
 * Outputs are sampled a quarter period after the falling edge.
 */
module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_RANDOM     = 400;
    localparam int NUM_CORNER     = 8;
    localparam int NUM_OPS        = NUM_RANDOM + NUM_CORNER;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (DIV_STEPS + 2) + RESET_CYCLES + 100;

    logic            clk;
    logic            reset;
    muldiv_req_t     req;
    logic            hold;
    logic [XLEN-1:0] result;

    int seed;
    int cycle_count = 0;

    muldiv_unit i_dut (
        .clk      (clk),
        .reset    (reset),
        .req_i    (req),
        .hold_o   (hold),
        .result_o (result)
    );

    bind muldiv_unit muldiv_properties i_properties (
        .clk    (clk),
        .reset  (reset),
        .req_i  (req_i),
        .hold_i (hold_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string       name,
                               input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            $display("Mismatch %s: observed 0x%08h, expected 0x%08h", name, observed, expected);
            $display("TEST FAILED");
            $fatal(1, "Check of %s failed", name);
        end
    endtask

    // About one operand in four is a corner value.
    function automatic logic [31:0] random_operand();
        logic [2:0] pick;
        if (($random(seed) & 3) == 0) begin
            pick = 3'($unsigned($random(seed)) % 5);
            case (pick)
                3'd0:    return 32'h0000_0000;
                3'd1:    return 32'h0000_0001;
                3'd2:    return 32'hffff_ffff;
                3'd3:    return 32'h8000_0000;
                default: return 32'h7fff_ffff;
            endcase
        end
        return $random(seed);
    endfunction

    // Cycle in which hold_o is first low, counting the request cycle as 1.
    function automatic int model_final_cycle(input iType_e op);
        case (op)
            MUL:                  return 3;
            MULH, MULHSU, MULHU:  return 4;
            DIV, DIVU, REM, REMU: return DIV_STEPS + 2;
            default:              return 1;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input muldiv_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] prod;
        logic        div_zero;
        logic        ovf;
        a        = r.first_operand;
        b        = r.second_operand;
        ua       = {32'b0, a};
        ub       = {32'b0, b};
        sa       = {{32{a[31]}}, a};
        sb       = {{32{b[31]}}, b};
        div_zero = (b == 32'h0);
        ovf      = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (r.operation)
            MUL: begin
                prod = ua * ub;
                return prod[31:0];
            end
            MULH: begin
                prod = sa * sb;                 // Modulo 2^64 gives the signed product.
                return prod[63:32];
            end
            MULHSU: begin
                prod = sa * ub;
                return prod[63:32];
            end
            MULHU: begin
                prod = ua * ub;
                return prod[63:32];
            end
            DIV: begin
                if (div_zero) return 32'hffff_ffff;
                if (ovf) return 32'h8000_0000;
                return $signed(a) / $signed(b);
            end
            DIVU:    return div_zero ? 32'hffff_ffff : a / b;
            REM: begin
                if (div_zero) return a;
                if (ovf) return 32'h0;
                return $signed(a) % $signed(b);
            end
            REMU:    return div_zero ? a : a % b;
            default: return 32'h0;
        endcase
    endfunction

    // Apply one request and hold it until the final cycle.
    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input iType_e op);
        int cycle;
        @(negedge clk);
        reset              = 1'b0;              // Reset ends with the first request.
        req.first_operand  = a;
        req.second_operand = b;
        req.operation      = op;
        cycle              = 1;
        #(CLK_PERIOD / 4);
        while (hold) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            cycle++;
        end
        check_value($sformatf("hold_o final cycle (%s)", op.name()),
                    cycle, model_final_cycle(op));
        check_value($sformatf("result_o (%s)", op.name()), result, model_result(req));
    endtask

    initial begin
        iType_e      op;
        iType_e      div_ops [4];
        logic [3:0]  idx;
        logic [31:0] a;
        logic [31:0] b;
        seed     = 32'h6f3d;
        div_ops  = '{DIV, DIVU, REM, REMU};
        reset    = 1'b1;
        req      = '0;
        repeat (RESET_CYCLES - 1) @(negedge clk);

        // Fixed RISC-V results for divide by zero and signed overflow.
        for (int i = 0; i < 4; i++) begin
            run_op(random_operand(), 32'h0, div_ops[i]);
            run_op(32'h8000_0000, 32'hffff_ffff, div_ops[i]);
        end

        // Back to back, mixed groups, non-M ops interleaved.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            idx = 4'($unsigned($random(seed)) % 10);
            op  = iType_e'(idx);
            a   = random_operand();
            b   = random_operand();
            run_op(a, b, op);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
muldiv_pkg.sv
mul.sv
div.sv
muldiv_unit.sv
muldiv_properties.sv
tb_muldiv.sv
